// ==== rtl/dsp_num_pkg.sv ====
package dsp_num_pkg;

    // Raw ADC sample, one per lane
    typedef logic signed [7:0]  code_t;

    // FFE tap weight
    typedef logic signed [7:0]  weight_t;

    // FFE sum before and after the shift, also the slicer threshold
    typedef logic signed [17:0] ffe_acc_t;

    // Right shift applied after the FFE and the channel filter
    typedef logic [3:0]         shift_t;

    // Channel estimate tap
    typedef logic signed [7:0]  chan_coef_t;

    // Code rebuilt from sliced bits, holds 3 full-scale taps
    typedef logic signed [9:0]  est_code_t;

    // Rebuilt code minus received code
    typedef logic signed [10:0] err_t;

    // Sum of squared errors over the detector window
    typedef logic [23:0]        sqerr_t;

endpackage

// ==== rtl/dsp_pipe_pkg.sv ====
package dsp_pipe_pkg;

    // FFE length in symbols
    parameter int ffe_taps = 3;

    // Channel estimate length, also the detector window
    parameter int chan_taps = 3;

    // Codes in to sliced bits out
    parameter int eq_latency = 1;

    // Sliced bits in to error word out
    parameter int chan_latency = 1;

    // One word of lookahead plus the flag register
    parameter int det_latency = 2;

    // ADC word in to aligned bits, flags and errors out
    parameter int total_latency = eq_latency + chan_latency + det_latency;

endpackage

// ==== rtl/dsp_cfg_if.sv ====
`timescale 1ns/100ps

interface dsp_cfg_if #(
    parameter int num_lanes = 4
);
    import dsp_num_pkg::*;
    import dsp_pipe_pkg::*;

    // Equalizer settings, indexed by lane then tap
    weight_t    [num_lanes-1:0][ffe_taps-1:0]  weights;
    shift_t     [num_lanes-1:0]                ffe_shift;
    ffe_acc_t   [num_lanes-1:0]                thresh;

    // Channel estimate, indexed by lane then tap
    chan_coef_t [num_lanes-1:0][chan_taps-1:0] chan_est;
    shift_t     [num_lanes-1:0]                chan_shift;

    // Driver side at the top level
    modport src (
        output weights, ffe_shift, thresh, chan_est, chan_shift
    );

    modport eq (
        input weights, ffe_shift, thresh
    );

    // Shared by error and detector stages
    modport chan (
        input chan_est, chan_shift
    );

endinterface

// ==== rtl/lane_delay_line.sv ====
`timescale 1ns/100ps

module lane_delay_line #(
    parameter type payload_t = logic,
    parameter int  depth     = 1
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  payload_t in_i,
    output payload_t taps_o [0:depth]
);
    payload_t stage_q [1:depth];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i <= depth; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[1] <= in_i;
            for (int i = 2; i <= depth; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // Tap 0 is the live word
    assign taps_o[0] = in_i;

    for (genvar g = 1; g <= depth; g++) begin : g_tap
        assign taps_o[g] = stage_q[g];
    end

    a_depth_min: assert property (@(posedge clk) depth >= 1)
        else $error("lane_delay_line needs at least one stage");

endmodule

// ==== rtl/equalize_stage.sv ====
`timescale 1ns/100ps

module equalize_stage #(
    parameter int num_lanes = 4
) (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  dsp_num_pkg::code_t [num_lanes-1:0] codes_i,
    dsp_cfg_if.eq                              cfg,
    output logic [num_lanes-1:0]               bits_o
);
    import dsp_num_pkg::*;
    import dsp_pipe_pkg::*;

    typedef code_t [num_lanes-1:0] code_word_t;

    localparam int win_len = num_lanes + ffe_taps - 1;

    code_word_t           code_taps [0:1];
    code_t                code_win  [win_len];
    ffe_acc_t             ffe_out   [num_lanes];
    logic [num_lanes-1:0] slice_bits;

    // Previous word feeds the taps that reach back past lane 0
    lane_delay_line #(
        .payload_t (code_word_t),
        .depth     (1)
    ) u_code_hist (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .in_i    (codes_i),
        .taps_o  (code_taps)
    );

    // Oldest first: tail of the previous word, then the current word
    always_comb begin
        for (int i = 0; i < ffe_taps - 1; i++) begin
            code_win[i] = code_taps[1][num_lanes - ffe_taps + 1 + i];
        end
        for (int i = 0; i < num_lanes; i++) begin
            code_win[ffe_taps - 1 + i] = code_taps[0][i];
        end
    end

    // FFE per lane, tap k weights the code k symbols back
    always_comb begin
        ffe_acc_t acc;
        for (int l = 0; l < num_lanes; l++) begin
            acc = '0;
            for (int k = 0; k < ffe_taps; k++) begin
                acc = acc + $signed(cfg.weights[l][k]) *
                            $signed(code_win[l + ffe_taps - 1 - k]);
            end
            ffe_out[l] = acc >>> cfg.ffe_shift[l];
        end
    end

    // Slicer
    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            slice_bits[l] = (ffe_out[l] >= $signed(cfg.thresh[l]));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bits_o <= '0;
        end else begin
            bits_o <= slice_bits;
        end
    end

    // Decisions stay defined once reset is released
    a_bits_known: assert property (@(posedge clk) rst_n_i |=> !$isunknown(bits_o))
        else $error("equalize_stage produced unknown bits");

endmodule

// ==== rtl/channel_error_stage.sv ====
`timescale 1ns/100ps

module channel_error_stage #(
    parameter int num_lanes = 4
) (
    input  logic                               clk,
    input  logic                               rst_n_i,
    input  dsp_num_pkg::code_t [num_lanes-1:0] codes_i,
    input  logic [num_lanes-1:0]               bits_i,
    dsp_cfg_if.chan                            cfg,
    output dsp_num_pkg::err_t [num_lanes-1:0]  err_o
);
    import dsp_num_pkg::*;
    import dsp_pipe_pkg::*;

    typedef code_t [num_lanes-1:0] code_word_t;
    typedef logic  [num_lanes-1:0] bit_word_t;

    localparam int win_len = num_lanes + chan_taps - 1;
    localparam int wide_w  = $bits(err_t) + 1;

    code_word_t               code_taps [0:eq_latency];
    bit_word_t                bit_taps  [0:1];
    logic                     bit_win   [win_len];
    est_code_t                est_code  [num_lanes];
    logic signed [wide_w-1:0] err_wide  [num_lanes];
    err_t [num_lanes-1:0]     err_d;
    logic [num_lanes-1:0]     err_fits;

    // Codes wait for their decisions from the equalizer
    lane_delay_line #(
        .payload_t (code_word_t),
        .depth     (eq_latency)
    ) u_code_align (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .in_i    (codes_i),
        .taps_o  (code_taps)
    );

    lane_delay_line #(
        .payload_t (bit_word_t),
        .depth     (1)
    ) u_bit_hist (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .in_i    (bits_i),
        .taps_o  (bit_taps)
    );

    always_comb begin
        for (int i = 0; i < chan_taps - 1; i++) begin
            bit_win[i] = bit_taps[1][num_lanes - chan_taps + 1 + i];
        end
        for (int i = 0; i < num_lanes; i++) begin
            bit_win[chan_taps - 1 + i] = bit_taps[0][i];
        end
    end

    always_comb begin
        est_code_t acc;
        for (int l = 0; l < num_lanes; l++) begin
            acc = '0;
            for (int j = 0; j < chan_taps; j++) begin
                // Bit 1 is +1, bit 0 is -1
                if (bit_win[l + chan_taps - 1 - j]) begin
                    acc = acc + $signed(cfg.chan_est[l][j]);
                end else begin
                    acc = acc - $signed(cfg.chan_est[l][j]);
                end
            end
            est_code[l] = acc >>> cfg.chan_shift[l];
            err_wide[l] = est_code[l] - $signed(code_taps[eq_latency][l]);
            err_d[l]    = err_t'(err_wide[l]);
            err_fits[l] = (err_wide[l] == $signed(err_d[l]));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            err_o <= '0;
        end else begin
            err_o <= err_d;
        end
    end

    a_err_range: assert property (@(posedge clk) disable iff (!rst_n_i) &err_fits)
        else $error("estimation error overflows err_t");

endmodule

// ==== rtl/flip_detect_stage.sv ====
`timescale 1ns/100ps

module flip_detect_stage #(
    parameter int num_lanes = 4
) (
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  logic [num_lanes-1:0]              bits_i,
    input  dsp_num_pkg::err_t [num_lanes-1:0] err_i,
    dsp_cfg_if.chan                           cfg,
    output logic [num_lanes-1:0]              bits_o,
    output logic [num_lanes-1:0]              flip_o,
    output dsp_num_pkg::err_t [num_lanes-1:0] err_o
);
    import dsp_num_pkg::*;
    import dsp_pipe_pkg::*;

    typedef err_t [num_lanes-1:0] err_word_t;
    typedef logic [num_lanes-1:0] bit_word_t;

    localparam int bit_depth = chan_latency + 1;
    localparam int diff_w    = $bits(err_t) + 2;

    err_word_t            err_taps [0:1];
    bit_word_t            bit_taps [0:bit_depth];
    err_t                 err_win  [2*num_lanes];
    logic [num_lanes-1:0] flip_d;
    logic [num_lanes-1:0] zero_win;

    // Hold word W while W+1 supplies the lookahead
    lane_delay_line #(.payload_t(err_word_t), .depth(1)) u_err_hold (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .in_i    (err_i),
        .taps_o  (err_taps)
    );

    lane_delay_line #(.payload_t(bit_word_t), .depth(bit_depth)) u_bit_align (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .in_i    (bits_i),
        .taps_o  (bit_taps)
    );

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            err_win[i]             = err_taps[1][i];
            err_win[num_lanes + i] = err_taps[0][i];
        end
    end

    always_comb begin
        logic signed [9:0]          d;
        logic signed [diff_w-1:0]   e_cur;
        logic signed [diff_w-1:0]   e_flip;
        logic signed [2*diff_w-1:0] sq_cur;
        logic signed [2*diff_w-1:0] sq_flip;
        sqerr_t                     cost_cur;
        sqerr_t                     cost_flip;
        for (int l = 0; l < num_lanes; l++) begin
            cost_cur    = '0;
            cost_flip   = '0;
            zero_win[l] = 1'b1;
            for (int j = 0; j < chan_taps; j++) begin
                d       = $signed({cfg.chan_est[l][j], 1'b0}) >>> cfg.chan_shift[l];
                e_cur   = err_win[l + j];
                // Flipping s[n] moves the rebuilt code by -s*d
                e_flip  = bit_taps[bit_depth][l] ? e_cur - d : e_cur + d;
                sq_cur  = e_cur * e_cur;
                sq_flip = e_flip * e_flip;
                cost_cur    = cost_cur + sqerr_t'(sq_cur);
                cost_flip   = cost_flip + sqerr_t'(sq_flip);
                zero_win[l] = zero_win[l] & (e_cur == '0);
            end
            flip_d[l] = (cost_flip < cost_cur);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bits_o <= '0;
            flip_o <= '0;
            err_o  <= '0;
        end else begin
            bits_o <= bit_taps[bit_depth];
            flip_o <= flip_d;
            err_o  <= err_taps[1];
        end
    end

    a_no_flag_zero_err: assert property (@(posedge clk) disable iff (!rst_n_i)
        (zero_win != '0) |=> ((flip_o & $past(zero_win)) == '0))
        else $error("flag raised on a lane with zero error window");

endmodule

// ==== rtl/rx_datapath_top.sv ====
`timescale 1ns/100ps

module rx_datapath_top #(
    parameter int num_lanes = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n_i,
    input  dsp_num_pkg::code_t      [num_lanes-1:0] adc_codes_i,
    input  dsp_num_pkg::weight_t    [num_lanes-1:0][dsp_pipe_pkg::ffe_taps-1:0]  weights_i,
    input  dsp_num_pkg::shift_t     [num_lanes-1:0] ffe_shift_i,
    input  dsp_num_pkg::ffe_acc_t   [num_lanes-1:0] thresh_i,
    input  dsp_num_pkg::chan_coef_t [num_lanes-1:0][dsp_pipe_pkg::chan_taps-1:0] chan_est_i,
    input  dsp_num_pkg::shift_t     [num_lanes-1:0] chan_shift_i,
    output logic                    [num_lanes-1:0] bits_o,
    output logic                    [num_lanes-1:0] flip_o,
    output dsp_num_pkg::err_t       [num_lanes-1:0] err_o
);
    import dsp_num_pkg::*;

    logic [num_lanes-1:0] eq_bits;
    err_t [num_lanes-1:0] chan_err;

    dsp_cfg_if #(
        .num_lanes (num_lanes)
    ) cfg_if ();

    // Static configuration levels
    assign cfg_if.weights    = weights_i;
    assign cfg_if.ffe_shift  = ffe_shift_i;
    assign cfg_if.thresh     = thresh_i;
    assign cfg_if.chan_est   = chan_est_i;
    assign cfg_if.chan_shift = chan_shift_i;

    equalize_stage #(
        .num_lanes (num_lanes)
    ) u_equalize (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .codes_i (adc_codes_i),
        .cfg     (cfg_if),
        .bits_o  (eq_bits)
    );

    // Raw codes are realigned inside the error stage
    channel_error_stage #(
        .num_lanes (num_lanes)
    ) u_chan_err (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .codes_i (adc_codes_i),
        .bits_i  (eq_bits),
        .cfg     (cfg_if),
        .err_o   (chan_err)
    );

    flip_detect_stage #(
        .num_lanes (num_lanes)
    ) u_flip_detect (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bits_i  (eq_bits),
        .err_i   (chan_err),
        .cfg     (cfg_if),
        .bits_o  (bits_o),
        .flip_o  (flip_o),
        .err_o   (err_o)
    );

endmodule

// ==== dv/rx_datapath_tests.svh ====
`ifndef RX_DATAPATH_TESTS_SVH
`define RX_DATAPATH_TESTS_SVH

function automatic int rand_in(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
endfunction

function automatic code_word_t random_word();
    code_word_t w;
    int         mag;
    for (int l = 0; l < num_lanes; l++) begin
        if (large_codes) begin
            mag  = rand_in(64, 127);
            w[l] = code_t'((rand_in(0, 1) == 1) ? mag : -mag);
        end else begin
            w[l] = code_t'(rand_in(-128, 127));
        end
    end
    return w;
endfunction

// Symbols before reset release read as zero codes
function automatic int code_at(input int n);
    code_word_t w;
    if (n < 0) return 0;
    w = code_q[n / num_lanes];
    return int'(w[n % num_lanes]);
endfunction

// Cleared history counts as bit 0
function automatic bit bit_at(input int n);
    int      l;
    int      acc;
    weight_t wt;
    if (n < 0) return 1'b0;
    l   = n % num_lanes;
    acc = 0;
    for (int k = 0; k < ffe_taps; k++) begin
        wt  = weights[l][k];
        acc = acc + int'(wt) * code_at(n - k);
    end
    acc = acc >>> ffe_shift[l];
    return acc >= int'(thresh[l]);
endfunction

function automatic int sym_at(input int n);
    return bit_at(n) ? 1 : -1;
endfunction

function automatic int err_at(input int n);
    int         l;
    int         est;
    chan_coef_t c;
    l   = n % num_lanes;
    est = 0;
    for (int j = 0; j < chan_taps; j++) begin
        c   = chan_est[l][j];
        est = est + int'(c) * sym_at(n - j);
    end
    est = est >>> chan_shift[l];
    return est - code_at(n);
endfunction

function automatic bit flip_at(input int n);
    int         l;
    int         e;
    int         d;
    int         ef;
    int         cost_cur;
    int         cost_flip;
    chan_coef_t c;
    l         = n % num_lanes;
    cost_cur  = 0;
    cost_flip = 0;
    for (int j = 0; j < chan_taps; j++) begin
        c         = chan_est[l][j];
        d         = (2 * int'(c)) >>> chan_shift[l];
        e         = err_at(n + j);
        ef        = e - sym_at(n) * d;
        cost_cur  = cost_cur + e * e;
        cost_flip = cost_flip + ef * ef;
    end
    return cost_flip < cost_cur;
endfunction

task automatic idle_cycles(input int n);
    repeat (n) step('0);
endtask

task automatic run_words(input int n);
    check_from = code_q.size();
    check_last = check_from + n - 1;
    for (int i = 0; i < n; i++) begin
        step(random_word());
    end
    // Flush so the last word and its lookahead reach the output
    repeat (total_latency) step('0);
    check_from = check_off;
endtask

task automatic check_outputs_zero(input string when);
    check_value(longint'(bits_o), 0, {"bits_o not zero ", when});
    check_value(longint'(flip_o), 0, {"flip_o not zero ", when});
    check_value(longint'(err_o), 0, {"err_o not zero ", when});
endtask

task automatic test_reset();
    int errs;
    errs = err_cnt;
    repeat (3) begin
        @(negedge clk);
        check_outputs_zero("during reset");
    end
    rst_n_i   = 1'b1;
    adc_codes = '0;
    code_q.push_back('0);
    // First word needs three more edges to reach the output
    repeat (3) begin
        @(negedge clk);
        check_outputs_zero("after reset");
        adc_codes = '0;
        code_q.push_back('0);
    end
    report_test("reset", errs);
endtask

task automatic test_passthrough();
    int errs;
    errs = err_cnt;
    for (int l = 0; l < num_lanes; l++) begin
        weights[l]    = '0;
        weights[l][0] = weight_t'(1);
        ffe_shift[l]  = '0;
        thresh[l]     = '0;
        chan_est[l]    = '0;
        chan_est[l][0] = chan_coef_t'(64);
        chan_shift[l]  = '0;
    end
    idle_cycles(6);
    run_words(40);
    report_test("passthrough", errs);
endtask

task automatic test_ffe();
    int errs;
    errs = err_cnt;
    for (int l = 0; l < num_lanes; l++) begin
        for (int k = 0; k < ffe_taps; k++) begin
            weights[l][k] = weight_t'(rand_in(-128, 127));
        end
        ffe_shift[l] = shift_t'(rand_in(0, 7));
        thresh[l]    = ffe_acc_t'(rand_in(-200, 200));
    end
    idle_cycles(6);
    run_words(40);
    report_test("ffe", errs);
endtask

task automatic test_channel();
    int errs;
    errs = err_cnt;
    for (int l = 0; l < num_lanes; l++) begin
        for (int j = 0; j < chan_taps; j++) begin
            chan_est[l][j] = chan_coef_t'(rand_in(-128, 127));
        end
        chan_shift[l] = shift_t'(rand_in(0, 3));
    end
    idle_cycles(6);
    run_words(40);
    report_test("channel", errs);
endtask

task automatic test_detector();
    int errs;
    int flags;
    errs = err_cnt;
    // Inverted cursor makes every decision on a large code wrong
    for (int l = 0; l < num_lanes; l++) begin
        weights[l]     = '0;
        weights[l][0]  = weight_t'(-1);
        ffe_shift[l]   = '0;
        thresh[l]      = '0;
        chan_est[l]    = '0;
        chan_est[l][0] = chan_coef_t'(40);
        chan_shift[l]  = '0;
    end
    large_codes = 1'b1;
    idle_cycles(6);
    flags = flag_cnt;
    run_words(30);
    // Every lane of every word is wrong and worth a flip
    check_value(longint'(flag_cnt - flags), longint'(30 * num_lanes),
                "detector missed wrong decisions");
    // Correct polarity leaves nothing to flag
    for (int l = 0; l < num_lanes; l++) begin
        weights[l][0] = weight_t'(1);
    end
    idle_cycles(6);
    flags = flag_cnt;
    run_words(30);
    check_value(longint'(flag_cnt - flags), 0, "detector flagged correct decisions");
    large_codes = 1'b0;
    report_test("detector", errs);
endtask

task automatic test_mixed();
    int errs;
    errs = err_cnt;
    for (int l = 0; l < num_lanes; l++) begin
        for (int k = 0; k < ffe_taps; k++) begin
            weights[l][k]  = weight_t'(rand_in(-128, 127));
            chan_est[l][k] = chan_coef_t'(rand_in(-128, 127));
        end
        ffe_shift[l]  = shift_t'(rand_in(0, 7));
        thresh[l]     = ffe_acc_t'(rand_in(-200, 200));
        chan_shift[l] = shift_t'(rand_in(0, 3));
    end
    idle_cycles(6);
    run_words(100);
    report_test("mixed", errs);
endtask

`endif

// ==== dv/rx_datapath_tb.sv ====
`timescale 1ns/100ps

module rx_datapath_tb;
    import dsp_num_pkg::*;
    import dsp_pipe_pkg::*;

    localparam int num_lanes = 4;
    // The directed tests need roughly 400 cycles
    localparam int max_cycles = 2000;
    localparam int check_off  = 32'h7fff_ffff;

    typedef code_t [num_lanes-1:0] code_word_t;

    logic                                      clk;
    logic                                      rst_n_i;
    code_word_t                                adc_codes;
    weight_t    [num_lanes-1:0][ffe_taps-1:0]  weights;
    shift_t     [num_lanes-1:0]                ffe_shift;
    ffe_acc_t   [num_lanes-1:0]                thresh;
    chan_coef_t [num_lanes-1:0][chan_taps-1:0] chan_est;
    shift_t     [num_lanes-1:0]                chan_shift;
    logic       [num_lanes-1:0]                bits_o;
    logic       [num_lanes-1:0]                flip_o;
    err_t       [num_lanes-1:0]                err_o;

    int         seed;
    int         cycle_cnt;
    int         check_cnt;
    int         err_cnt;
    int         test_cnt;
    int         check_from;
    int         check_last;
    // Flags seen on compared words
    int         flag_cnt;
    bit         large_codes;
    // Every word driven since reset, index is the word number
    code_word_t code_q [$];

    rx_datapath_top #(
        .num_lanes (num_lanes)
    ) dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .adc_codes_i  (adc_codes),
        .weights_i    (weights),
        .ffe_shift_i  (ffe_shift),
        .thresh_i     (thresh),
        .chan_est_i   (chan_est),
        .chan_shift_i (chan_shift),
        .bits_o       (bits_o),
        .flip_o       (flip_o),
        .err_o        (err_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input longint got, input longint exp, input string what);
        check_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("FAILED at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        $display("%-12s done, %0d errors", name, err_cnt - errs_before);
    endtask

    task automatic compare_word(input int w);
        int   n;
        err_t e;
        for (int l = 0; l < num_lanes; l++) begin
            n = w * num_lanes + l;
            e = err_o[l];
            flag_cnt = flag_cnt + int'(flip_o[l]);
            check_value(longint'(bits_o[l]), longint'(bit_at(n)),
                        $sformatf("bits_o word %0d lane %0d", w, l));
            check_value(longint'(flip_o[l]), longint'(flip_at(n)),
                        $sformatf("flip_o word %0d lane %0d", w, l));
            check_value(longint'(e), longint'(err_at(n)),
                        $sformatf("err_o word %0d lane %0d", w, l));
        end
    endtask

    // One cycle: compare the word leaving the pipe, then drive the next one
    task automatic step(input code_word_t w);
        int idx;
        @(negedge clk);
        idx = code_q.size() - total_latency;
        if (idx >= check_from && idx <= check_last) begin
            compare_word(idx);
        end
        adc_codes = w;
        code_q.push_back(w);
    endtask

    `include "rx_datapath_tests.svh"

    initial begin
        seed        = 32'h9503_3b77;
        cycle_cnt   = 0;
        check_cnt   = 0;
        err_cnt     = 0;
        test_cnt    = 0;
        flag_cnt    = 0;
        check_from  = check_off;
        check_last  = -1;
        large_codes = 1'b0;
        rst_n_i     = 1'b0;
        adc_codes   = '0;
        weights     = '0;
        ffe_shift   = '0;
        thresh      = '0;
        chan_est    = '0;
        chan_shift  = '0;

        test_reset();
        test_passthrough();
        test_ffe();
        test_channel();
        test_detector();
        test_mixed();

        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
rtl/dsp_num_pkg.sv
rtl/dsp_pipe_pkg.sv
rtl/dsp_cfg_if.sv
rtl/lane_delay_line.sv
rtl/equalize_stage.sv
rtl/channel_error_stage.sv
rtl/flip_detect_stage.sv
rtl/rx_datapath_top.sv
+incdir+dv
dv/rx_datapath_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module rx_datapath_tb \
    -o rx_datapath_sim

./obj_dir/rx_datapath_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
